// ==== logic/exu_pkg.sv ====
package exu_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_XOR  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_AND  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  localparam alu_op_t ALU_SLE  = 4'd10;
  localparam alu_op_t ALU_SLEU = 4'd11;

  // major opcodes in inst[6:0]
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // csr funct3 in inst[14:12]
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // funct3 == 0 system instructions are told apart by imm
  localparam logic [11:0] IMM_ECALL = 12'h000;
  localparam logic [11:0] IMM_MRET  = 12'h302;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam xlen_t MCAUSE_ECALL = 32'd11;

  localparam int RAM_WORDS = 64;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  typedef enum logic [1:0] {
    IDLE,
    ALU_DONE,
    MEM_REQ,
    MEM_DONE
  } stage_state_e;

endpackage

// ==== logic/exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
  input  xlen_t   src1_i,
  input  xlen_t   src2_i,
  input  alu_op_t op_i,
  output xlen_t   res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = xlen_t'($signed(src1_i) >>> shamt);
      // compares give 0 or 1
      ALU_SLT:  res_o = {31'b0, lt_s};
      ALU_SLTU: res_o = {31'b0, lt_u};
      ALU_SLE:  res_o = {31'b0, lt_s | eq};
      ALU_SLEU: res_o = {31'b0, lt_u | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== logic/exu_csr.sv ====
`timescale 1ns/10ps

module exu_csr import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wen_i,
  input  logic      ecall_i,
  input  csr_addr_t waddr_i,
  input  xlen_t     wdata_i,
  input  xlen_t     pc_i,
  input  csr_addr_t raddr_i,
  output xlen_t     rdata_o,
  output xlen_t     mepc_o,
  output xlen_t     mtvec_o
);

  xlen_t mstatus_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (wen_i) begin
      case (waddr_i)
        CSR_MSTATUS: mstatus_q <= wdata_i;
        CSR_MTVEC:   mtvec_q   <= wdata_i;
        CSR_MEPC:    mepc_q    <= wdata_i;
        CSR_MCAUSE:  mcause_q  <= wdata_i;
        default: ;
      endcase
      // on ecall mcause goes through the main port and mepc through this one
      if (ecall_i) begin
        mepc_q <= pc_i;
      end
    end
  end

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

endmodule

// ==== logic/exu_redirect.sv ====
`timescale 1ns/10ps

module exu_redirect import exu_pkg::*; (
  input  xlen_t     inst_i,
  input  xlen_t     imm_i,
  input  xlen_t     src1_i,
  input  xlen_t     pc_i,
  input  xlen_t     target_i,
  input  xlen_t     alu_res_i,
  input  xlen_t     csr_rdata_i,
  input  xlen_t     mepc_i,
  input  xlen_t     mtvec_i,
  input  alu_op_t   alu_op_i,
  input  logic      system_i,
  input  logic      system_func3_i,
  output logic      take_o,
  output logic      ecall_o,
  output xlen_t     npc_o,
  output csr_addr_t csr_addr_o,
  output xlen_t     csr_wdata_o
);

  logic [6:0] opcode;
  logic [2:0] func3;
  logic       is_ecall;
  logic       is_mret;
  logic       br_take;

  assign opcode   = inst_i[6:0];
  assign func3    = inst_i[14:12];
  assign is_ecall = system_i & system_func3_i & (imm_i[11:0] == IMM_ECALL);
  assign is_mret  = system_i & system_func3_i & (imm_i[11:0] == IMM_MRET);
  assign ecall_o  = is_ecall;

  // beq uses SUB and every other compare takes on nonzero
  always_comb begin
    case (alu_op_i)
      ALU_SUB: br_take = ~|alu_res_i;
      ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU: br_take = |alu_res_i;
      default: br_take = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_JAL, OP_JALR: take_o = 1'b1;
      OP_BRANCH:       take_o = br_take;
      OP_SYSTEM:       take_o = is_ecall | is_mret;
      default:         take_o = 1'b0;
    endcase
  end

  // fall-through pc when nothing is taken
  assign npc_o = is_ecall ? mtvec_i :
                 is_mret  ? mepc_i :
                 take_o   ? target_i : pc_i + 32'd4;

  assign csr_addr_o = is_ecall ? CSR_MCAUSE :
                      is_mret  ? CSR_MSTATUS : imm_i[11:0];

  always_comb begin
    if (is_ecall) begin
      csr_wdata_o = MCAUSE_ECALL;
    end else if (is_mret) begin
      // mpie set and mie restored from mpie
      csr_wdata_o = {csr_rdata_i[31:8], 1'b1, csr_rdata_i[6:4], csr_rdata_i[7],
                     csr_rdata_i[2:0]};
    end else begin
      case (func3)
        F3_CSRRW, F3_CSRRWI: csr_wdata_o = src1_i;
        F3_CSRRS, F3_CSRRSI: csr_wdata_o = csr_rdata_i | src1_i;
        F3_CSRRC, F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_i;
        default:             csr_wdata_o = '0;
      endcase
    end
  end

endmodule

// ==== logic/exu_stage.sv ====
`timescale 1ns/10ps

module exu_stage import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  input  xlen_t    inst_i,
  input  xlen_t    imm_i,
  input  xlen_t    op1_i,
  input  xlen_t    op2_i,
  input  xlen_t    op_j_i,
  input  xlen_t    pc_i,
  input  alu_op_t  alu_op_i,
  input  reg_idx_t rd_i,
  input  logic     ren_i,
  input  logic     wen_i,
  input  logic     system_i,
  input  logic     system_func3_i,
  input  logic     csr_wen_i,

  input  logic     valid_i,
  output logic     ready_o,
  output logic     valid_o,
  input  logic     next_ready_i,

  output logic     mem_avalid_o,
  output logic     mem_ren_o,
  output logic     mem_wen_o,
  output xlen_t    mem_addr_o,
  output xlen_t    mem_wdata_o,
  input  logic     mem_rvalid_i,
  input  logic     mem_wready_i,
  input  xlen_t    mem_rdata_i,

  input  xlen_t    csr_rdata_i,
  input  xlen_t    alu_res_i,
  input  logic     take_i,

  output logic     csr_wen_o,
  output xlen_t    src1_o,
  output xlen_t    src2_o,
  output alu_op_t  alu_op_o,
  output xlen_t    inst_o,
  output xlen_t    imm_o,
  output xlen_t    pc_o,
  output xlen_t    target_o,
  output logic     system_o,
  output logic     system_func3_o,
  output reg_idx_t rd_o,
  output xlen_t    reg_wdata_o,
  output logic     redirect_o
);

  stage_state_e state_q, state_d, state_xfer;

  logic     xfer;
  logic     retire;
  logic     mem_ans;
  logic     ren_q, wen_q, system_q, func3_q, csr_wen_q;
  xlen_t    inst_q, imm_q, src1_q, src2_q, pc_q, target_q, addr_q, load_q;
  alu_op_t  alu_op_q;
  reg_idx_t rd_q;

  assign valid_o = (state_q == ALU_DONE) || (state_q == MEM_DONE);
  assign ready_o = (state_q == IDLE) || (valid_o && next_ready_i);
  assign xfer    = valid_i & ready_o;
  assign retire  = valid_o & next_ready_i;
  assign mem_ans = (ren_q & mem_rvalid_i) | (wen_q & mem_wready_i);

  assign state_xfer = (ren_i | wen_i) ? MEM_REQ : ALU_DONE;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (xfer) state_d = state_xfer;
      end
      ALU_DONE, MEM_DONE: begin
        // a new op may enter in the retire cycle
        if (retire) state_d = xfer ? state_xfer : IDLE;
      end
      MEM_REQ: begin
        if (mem_ans) state_d = MEM_DONE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      ren_q     <= 1'b0;
      wen_q     <= 1'b0;
      system_q  <= 1'b0;
      func3_q   <= 1'b0;
      csr_wen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (xfer) begin
        ren_q     <= ren_i;
        wen_q     <= wen_i;
        system_q  <= system_i;
        func3_q   <= system_func3_i;
        csr_wen_q <= csr_wen_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      inst_q   <= inst_i;
      imm_q    <= imm_i;
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      pc_q     <= pc_i;
      alu_op_q <= alu_op_i;
      rd_q     <= rd_i;
      target_q <= op_j_i + imm_i;
      addr_q   <= op1_i + imm_i;
    end
    if (state_q == MEM_REQ && ren_q && mem_rvalid_i) begin
      load_q <= mem_rdata_i;
    end
  end

  // request drops in the answer cycle
  assign mem_avalid_o = (state_q == MEM_REQ) & ~mem_ans;
  assign mem_ren_o    = ren_q;
  assign mem_wen_o    = wen_q;
  assign mem_addr_o   = addr_q;
  assign mem_wdata_o  = src2_q;

  // csr write lands on the retire edge
  assign csr_wen_o = csr_wen_q & retire;

  assign src1_o         = src1_q;
  assign src2_o         = src2_q;
  assign alu_op_o       = alu_op_q;
  assign inst_o         = inst_q;
  assign imm_o          = imm_q;
  assign pc_o           = pc_q;
  assign target_o       = target_q;
  assign system_o       = system_q;
  assign system_func3_o = func3_q;
  assign rd_o           = rd_q;

  assign reg_wdata_o = (rd_q == '0) ? '0 :
                       ren_q        ? load_q :
                       system_q     ? csr_rdata_i : alu_res_i;

  assign redirect_o = take_i & valid_o;

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/10ps

module data_ram import exu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  avalid_i,
  input  logic  ren_i,
  input  logic  wen_i,
  input  xlen_t addr_i,
  input  xlen_t wdata_i,
  output logic  rvalid_o,
  output logic  wready_o,
  output xlen_t rdata_o
);

  xlen_t mem [RAM_WORDS];

  logic              rvalid_q;
  logic              wready_q;
  logic [RAM_AW-1:0] idx;
  xlen_t             rdata_q;

  // word index from the byte address
  assign idx = addr_i[RAM_AW+1:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
      wready_q <= 1'b0;
    end else begin
      rvalid_q <= avalid_i & ren_i;
      wready_q <= avalid_i & wen_i;
    end
  end

  always_ff @(posedge clk) begin
    if (avalid_i & wen_i) begin
      mem[idx] <= wdata_i;
    end
    if (avalid_i & ren_i) begin
      rdata_q <= mem[idx];
    end
  end

  assign rvalid_o = rvalid_q;
  assign wready_o = wready_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== logic/exu_top.sv ====
`timescale 1ns/10ps

module exu_top import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  output logic     ready_o,
  input  xlen_t    inst_i,
  input  xlen_t    imm_i,
  input  xlen_t    op1_i,
  input  xlen_t    op2_i,
  input  xlen_t    op_j_i,
  input  xlen_t    pc_i,
  input  alu_op_t  alu_op_i,
  input  reg_idx_t rd_i,
  input  logic     ren_i,
  input  logic     wen_i,
  input  logic     system_i,
  input  logic     system_func3_i,
  input  logic     csr_wen_i,
  output logic     valid_o,
  input  logic     next_ready_i,
  output reg_idx_t rd_o,
  output xlen_t    reg_wdata_o,
  output logic     redirect_o,
  output xlen_t    npc_o
);

  logic      mem_avalid, mem_ren, mem_wen, mem_rvalid, mem_wready;
  xlen_t     mem_addr, mem_wdata, mem_rdata;
  logic      csr_wen_commit, csr_ecall, take, system, system_func3;
  csr_addr_t csr_waddr;
  xlen_t     csr_wdata, csr_rdata, mepc, mtvec;
  xlen_t     src1, src2, inst, imm, pc, target, alu_res;
  alu_op_t   alu_op;

  exu_stage exu_stage_inst (
    .clk, .rst,
    .inst_i, .imm_i, .op1_i, .op2_i, .op_j_i, .pc_i, .alu_op_i, .rd_i,
    .ren_i, .wen_i, .system_i, .system_func3_i, .csr_wen_i,
    .valid_i, .ready_o, .valid_o, .next_ready_i,
    .mem_avalid_o(mem_avalid), .mem_ren_o(mem_ren), .mem_wen_o(mem_wen),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_rvalid_i(mem_rvalid),
    .mem_wready_i(mem_wready), .mem_rdata_i(mem_rdata),
    .csr_rdata_i(csr_rdata), .alu_res_i(alu_res), .take_i(take),
    .csr_wen_o(csr_wen_commit), .src1_o(src1), .src2_o(src2), .alu_op_o(alu_op),
    .inst_o(inst), .imm_o(imm), .pc_o(pc), .target_o(target), .system_o(system),
    .system_func3_o(system_func3), .rd_o, .reg_wdata_o, .redirect_o
  );

  exu_alu exu_alu_inst (.src1_i(src1), .src2_i(src2), .op_i(alu_op), .res_o(alu_res));

  exu_csr exu_csr_inst (
    .clk, .rst, .wen_i(csr_wen_commit), .ecall_i(csr_ecall), .waddr_i(csr_waddr),
    .wdata_i(csr_wdata), .pc_i(pc), .raddr_i(csr_waddr), .rdata_o(csr_rdata),
    .mepc_o(mepc), .mtvec_o(mtvec)
  );

  exu_redirect exu_redirect_inst (
    .inst_i(inst), .imm_i(imm), .src1_i(src1), .pc_i(pc), .target_i(target),
    .alu_res_i(alu_res), .csr_rdata_i(csr_rdata), .mepc_i(mepc), .mtvec_i(mtvec),
    .alu_op_i(alu_op), .system_i(system), .system_func3_i(system_func3),
    .take_o(take), .ecall_o(csr_ecall), .npc_o, .csr_addr_o(csr_waddr),
    .csr_wdata_o(csr_wdata)
  );

  data_ram data_ram_inst (
    .clk, .rst, .avalid_i(mem_avalid), .ren_i(mem_ren), .wen_i(mem_wen),
    .addr_i(mem_addr), .wdata_i(mem_wdata), .rvalid_o(mem_rvalid),
    .wready_o(mem_wready), .rdata_o(mem_rdata)
  );

endmodule

// ==== sim/exu_tests.svh ====
localparam xlen_t INST_OP     = 32'h0000_0033;
localparam xlen_t INST_BRANCH = {25'b0, OP_BRANCH};
localparam xlen_t INST_JAL    = {25'b0, OP_JAL};
localparam xlen_t INST_JALR   = {25'b0, OP_JALR};
localparam xlen_t INST_LOAD   = {25'b0, OP_LOAD};
localparam xlen_t INST_STORE  = {25'b0, OP_STORE};
localparam xlen_t INST_SYSTEM = {25'b0, OP_SYSTEM};

function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b);
  logic [4:0] sh;
  sh = b[4:0];
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a + ~b + 32'd1;
    ALU_XOR:  return (a | b) & ~(a & b);
    ALU_OR:   return a | b;
    ALU_AND:  return a & b;
    ALU_SLL:  return a << sh;
    ALU_SRL:  return a >> sh;
    // sign fill from the top
    ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
    ALU_SLE:  return ($signed(b) < $signed(a)) ? 32'd0 : 32'd1;
    ALU_SLEU: return (b < a) ? 32'd0 : 32'd1;
    default:  return 32'd0;
  endcase
endfunction

// one transfer, wait for valid_o, hold off retire for stall cycles, then retire
task automatic issue_op(input xlen_t inst, input xlen_t imm, input xlen_t op1,
                        input xlen_t op2, input xlen_t op_j, input xlen_t pc,
                        input alu_op_t op, input reg_idx_t rd, input logic ren,
                        input logic wen, input logic sys, input logic sys_f3,
                        input logic csr_wen, input int stall);
  int lat;
  @(posedge clk);
  valid_i        <= 1'b1;
  inst_i         <= inst;
  imm_i          <= imm;
  op1_i          <= op1;
  op2_i          <= op2;
  op_j_i         <= op_j;
  pc_i           <= pc;
  alu_op_i       <= op;
  rd_i           <= rd;
  ren_i          <= ren;
  wen_i          <= wen;
  system_i       <= sys;
  system_func3_i <= sys_f3;
  csr_wen_i      <= csr_wen;
  @(negedge clk);
  while (!ready_o) @(negedge clk);
  @(posedge clk);
  valid_i <= 1'b0;
  issued++;
  lat = 0;
  do begin
    @(negedge clk);
    lat++;
  end while (!valid_o);
  check_eq(lat, (ren | wen) ? 3 : 1, "cycles from transfer to valid_o");
  check_eq(rd_o, rd, "rd_o echo");
  got_data     = reg_wdata_o;
  got_redirect = redirect_o;
  got_npc      = npc_o;
  repeat (stall) begin
    @(negedge clk);
    check_eq(valid_o, 1'b1, "valid_o held under back-pressure");
    check_eq(ready_o, 1'b0, "ready_o low under back-pressure");
    check_eq(reg_wdata_o, got_data, "reg_wdata_o held under back-pressure");
  end
  @(posedge clk) next_ready_i <= 1'b1;
  @(posedge clk) next_ready_i <= 1'b0;
endtask

task automatic csr_op(input logic [2:0] f3, input csr_addr_t addr, input xlen_t src,
                      input logic wen, input xlen_t exp_old, input string msg);
  issue_op({17'b0, f3, 5'b0, OP_SYSTEM}, {20'b0, addr}, src, 0, 0, 0, ALU_ADD, 4'd5,
           0, 0, 1, 0, wen, 0);
  check_eq(got_data, exp_old, msg);
endtask

task automatic alu_results();
  xlen_t a, b;
  for (int i = 0; i < 12; i++) begin
    a = $random(seed);
    b = $random(seed);
    if (alu_op_t'(i) == ALU_SLEU) b = a;
    issue_op(INST_OP, 0, a, b, 0, 0, alu_op_t'(i), reg_idx_t'(i + 1), 0, 0, 0, 0, 0, 0);
    check_eq(got_data, alu_model(alu_op_t'(i), a, b), "alu result");
  end
  // x0 destination always reads back zero
  issue_op(INST_OP, 0, 32'h1234_5678, 32'h1, 0, 0, ALU_ADD, 4'd0, 0, 0, 0, 0, 0, 0);
  check_eq(got_data, 0, "alu result with rd 0");
endtask

task automatic branch_redirects();
  xlen_t a, b, pc, imm;
  alu_op_t op;
  logic take;
  for (int i = 0; i < 8; i++) begin
    a    = $random(seed);
    b    = (i % 2 == 1) ? a : xlen_t'($random(seed));
    op   = (i < 4) ? ALU_SUB : ALU_XOR;
    pc   = $random(seed) & 32'hffff_fffc;
    imm  = $random(seed) & 32'h0000_0ffc;
    take = (op == ALU_SUB) ? (a == b) : (a != b);
    issue_op(INST_BRANCH, imm, a, b, pc, pc, op, 4'd0, 0, 0, 0, 0, 0, 0);
    check_eq(got_redirect, take, "branch taken");
    if (take) check_eq(got_npc, pc + imm, "branch target");
  end
  pc  = $random(seed) & 32'hffff_fffc;
  imm = $random(seed) & 32'h000f_fffc;
  issue_op(INST_JAL, imm, pc, 32'd4, pc, pc, ALU_ADD, 4'd1, 0, 0, 0, 0, 0, 0);
  check_eq(got_redirect, 1'b1, "jal redirect");
  check_eq(got_npc, pc + imm, "jal target");
  check_eq(got_data, pc + 32'd4, "jal link");
  a = $random(seed) & 32'hffff_fffc;
  issue_op(INST_JALR, imm, pc, 32'd4, a, pc, ALU_ADD, 4'd1, 0, 0, 0, 0, 0, 0);
  check_eq(got_redirect, 1'b1, "jalr redirect");
  check_eq(got_npc, a + imm, "jalr target");
endtask

task automatic store_load_words();
  xlen_t addr [4];
  xlen_t data [4];
  // one word from each quarter keeps the addresses distinct
  for (int i = 0; i < 4; i++) begin
    addr[i] = (i * 16 + ($random(seed) & 15)) << 2;
    data[i] = $random(seed);
    issue_op(INST_STORE, 32'd8, addr[i] - 32'd8, data[i], 0, 0, ALU_ADD, 4'd0,
             0, 1, 0, 0, 0, 0);
  end
  for (int i = 3; i >= 0; i--) begin
    issue_op(INST_LOAD, 32'd8, addr[i] - 32'd8, 0, 0, 0, ALU_ADD, reg_idx_t'(i + 1),
             1, 0, 0, 0, 0, 0);
    check_eq(got_data, data[i], "load data");
  end
endtask

task automatic mtvec_mstatus_access();
  xlen_t v;
  v = $random(seed);
  csr_op(F3_CSRRW, CSR_MTVEC, v, 1, mtvec_m, "csrrw mtvec old value");
  mtvec_m = v;
  csr_op(F3_CSRRS, CSR_MTVEC, 0, 0, mtvec_m, "mtvec read back");
  v = $random(seed);
  csr_op(F3_CSRRS, CSR_MSTATUS, v, 1, mstatus_m, "csrrs mstatus old value");
  mstatus_m = mstatus_m | v;
  csr_op(F3_CSRRS, CSR_MSTATUS, 0, 0, mstatus_m, "mstatus after set");
  v = $random(seed);
  csr_op(F3_CSRRC, CSR_MSTATUS, v, 1, mstatus_m, "csrrc mstatus old value");
  mstatus_m = mstatus_m & ~v;
  csr_op(F3_CSRRS, CSR_MSTATUS, 0, 0, mstatus_m, "mstatus after clear");
endtask

task automatic ecall_mret_flow();
  xlen_t pc;
  xlen_t old;
  pc = $random(seed) & 32'hffff_fffc;
  issue_op(INST_SYSTEM, {20'b0, IMM_ECALL}, 0, 0, 0, pc, ALU_ADD, 4'd0, 0, 0, 1, 1, 1, 0);
  check_eq(got_redirect, 1'b1, "ecall redirect");
  check_eq(got_npc, mtvec_m, "ecall target");
  mcause_m = 32'd11;
  mepc_m   = pc;
  csr_op(F3_CSRRS, CSR_MCAUSE, 0, 0, mcause_m, "mcause after ecall");
  csr_op(F3_CSRRS, CSR_MEPC, 0, 0, mepc_m, "mepc after ecall");
  issue_op(INST_SYSTEM, {20'b0, IMM_MRET}, 0, 0, 0, pc, ALU_ADD, 4'd0, 0, 0, 1, 1, 1, 0);
  check_eq(got_redirect, 1'b1, "mret redirect");
  check_eq(got_npc, mepc_m, "mret target");
  old          = mstatus_m;
  mstatus_m[7] = 1'b1;
  mstatus_m[3] = old[7];
  csr_op(F3_CSRRS, CSR_MSTATUS, 0, 0, mstatus_m, "mstatus after mret");
endtask

task automatic stall_burst();
  xlen_t a, b;
  alu_op_t op;
  int base;
  base = retired;
  for (int i = 0; i < 8; i++) begin
    a  = $random(seed);
    b  = $random(seed);
    op = alu_op_t'(($random(seed) & 32'h7fff_ffff) % 12);
    issue_op(INST_OP, 0, a, b, 0, 0, op, reg_idx_t'(i + 3), 0, 0, 0, 0, 0,
             ($random(seed) & 7) + 1);
    check_eq(got_data, alu_model(op, a, b), "alu result under back-pressure");
  end
  check_eq(retired - base, 8, "retire count over the burst");
endtask

// ==== sim/tb_exu.sv ====
`timescale 1ns/10ps

module tb_exu import exu_pkg::*; ();

  // ops issued over all tests in exu_tests.svh
  localparam int NUM_OPS     = 50;
  localparam int CYCLE_LIMIT = 40 * NUM_OPS + 100;

  logic     clk = 1'b0;
  logic     rst;
  logic     valid_i, ready_o, valid_o, next_ready_i;
  xlen_t    inst_i, imm_i, op1_i, op2_i, op_j_i, pc_i;
  alu_op_t  alu_op_i;
  reg_idx_t rd_i, rd_o;
  logic     ren_i, wen_i, system_i, system_func3_i, csr_wen_i;
  xlen_t    reg_wdata_o, npc_o;
  logic     redirect_o;

  integer   seed = 32'h5e9b;
  int       cycles = 0;
  int       issued = 0;
  int       retired = 0;

  // response of the last op as sampled when valid_o first rises
  xlen_t    got_data, got_npc;
  logic     got_redirect;

  // csr values as the testbench expects them
  xlen_t    mstatus_m, mtvec_m, mepc_m, mcause_m;

  exu_top exu_top_inst (
    .clk(clk), .rst(rst), .valid_i(valid_i), .ready_o(ready_o),
    .inst_i(inst_i), .imm_i(imm_i), .op1_i(op1_i), .op2_i(op2_i), .op_j_i(op_j_i),
    .pc_i(pc_i), .alu_op_i(alu_op_i), .rd_i(rd_i), .ren_i(ren_i), .wen_i(wen_i),
    .system_i(system_i), .system_func3_i(system_func3_i), .csr_wen_i(csr_wen_i),
    .valid_o(valid_o), .next_ready_i(next_ready_i), .rd_o(rd_o),
    .reg_wdata_o(reg_wdata_o), .redirect_o(redirect_o), .npc_o(npc_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1);
    end
  end

  // valid_o and next_ready_i both high at a negedge means a retire on the next edge
  always @(negedge clk) begin
    if (!rst && valid_o && next_ready_i) begin
      retired <= retired + 1;
    end
  end

  task automatic check_eq(input xlen_t actual, input xlen_t expected, input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  `include "exu_tests.svh"

  initial begin
    rst            = 1'b1;
    valid_i        = 1'b0;
    next_ready_i   = 1'b0;
    inst_i         = '0;
    imm_i          = '0;
    op1_i          = '0;
    op2_i          = '0;
    op_j_i         = '0;
    pc_i           = '0;
    alu_op_i       = ALU_ADD;
    rd_i           = '0;
    ren_i          = 1'b0;
    wen_i          = 1'b0;
    system_i       = 1'b0;
    system_func3_i = 1'b0;
    csr_wen_i      = 1'b0;
    mstatus_m      = '0;
    mtvec_m        = '0;
    mepc_m         = '0;
    mcause_m       = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_eq(ready_o, 1'b1, "ready_o after reset");
    check_eq(valid_o, 1'b0, "valid_o after reset");
    check_eq(redirect_o, 1'b0, "redirect_o after reset");
    alu_results();
    branch_redirects();
    store_load_words();
    mtvec_mstatus_access();
    ecall_mret_flow();
    stall_burst();
    check_eq(retired, issued, "retire count over the run");
    $display("No errors");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_csr.sv
logic/exu_redirect.sv
logic/exu_stage.sv
logic/data_ram.sv
logic/exu_top.sv
sim/tb_exu.sv
+incdir+sim
